// File: build.f
hdl/soc_map_pkg.sv
hdl/soc_bus_pkg.sv
hdl/l2_mem.sv
hdl/apb_timeout_timer.sv
hdl/apb_bridge_fsm.sv
hdl/ctrl_regs.sv
hdl/addr_decoder.sv
hdl/soc_top.sv
verification/soc_assert.sv
verification/soc_checker.sv
verification/soc_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the SoC fabric testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module soc_tb -o soc_sim &&
./obj_dir/soc_sim | tee /dev/stderr | grep -qx "Simulation passed" || exit 1

// File: verification/soc_tb.sv
// SoC fabric testbench
`timescale 1ns/1ps
`default_nettype none

module soc_tb;

  localparam int unsigned L2NumWords       = 1024;
  localparam int unsigned ApbTimeoutCycles = 16;
  localparam int unsigned NumOps           = 80;
  localparam int unsigned WatchdogCycles   = NumOps * (ApbTimeoutCycles + 10) + 20;

  logic        clk;
  logic        reset;
  logic        req_valid;
  logic        req_we;
  logic [63:0] req_addr;
  logic [63:0] req_wdata;
  logic [7:0]  req_be;
  logic        resp_valid;
  logic [63:0] resp_rdata;
  logic        resp_err;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [63:0] exit_val;
  logic        stall;
  int          test_id;
  int          seed;
  int          waits;
  int          missing;
  int          check_errors;
  logic [31:0] slave_regs [1024];

  always #10 clk = ~clk;

  soc_top #(
    .L2NumWords      (L2NumWords),
    .ApbTimeoutCycles(ApbTimeoutCycles)
  ) DUT (
    .clk_i(clk), .reset_i(reset),
    .req_valid_i(req_valid), .req_we_i(req_we), .req_addr_i(req_addr),
    .req_wdata_i(req_wdata), .req_be_i(req_be),
    .resp_valid_o(resp_valid), .resp_rdata_o(resp_rdata), .resp_err_o(resp_err),
    .uart_psel_o(psel), .uart_penable_o(penable), .uart_pwrite_o(pwrite),
    .uart_paddr_o(paddr), .uart_pwdata_o(pwdata), .uart_prdata_i(prdata),
    .uart_pready_i(pready), .uart_pslverr_i(pslverr), .exit_o(exit_val)
  );

  soc_checker #(
    .L2NumWords(L2NumWords)
  ) i_checker (
    .clk_i(clk), .reset_i(reset),
    .req_valid_i(req_valid), .req_we_i(req_we), .req_addr_i(req_addr),
    .req_wdata_i(req_wdata), .req_be_i(req_be),
    .resp_valid_i(resp_valid), .resp_rdata_i(resp_rdata), .resp_err_i(resp_err),
    .exit_i(exit_val), .psel_i(psel), .stall_i(stall), .test_id_i(test_id),
    .err_count_o(check_errors)
  );

  ////////////////////////////////////////////////////////////////////////////
  // APB slave with 0 to 3 wait cycles
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (psel && !penable) begin
      waits  = $random(seed) & 3;
      pready = 1'b0;
    end else if (psel && penable && !pready) begin
      if (stall) begin
        pready = 1'b0;
      end else if (waits == 0) begin
        pready  = 1'b1;
        pslverr = (paddr >= 32'h800);
        if (pslverr) begin
          prdata = '0;
        end else begin
          prdata = slave_regs[paddr[11:2]];
          if (pwrite) begin
            slave_regs[paddr[11:2]] = pwdata;
          end
        end
      end else begin
        waits--;
      end
    end else begin
      pready  = 1'b0;
      pslverr = 1'b0;
    end
  end

  task automatic access(input logic we, input logic [63:0] addr, input logic [63:0] wdata,
                        input logic [7:0] be);
    int cycles;
    cycles    = 0;
    req_valid = 1'b1;
    req_we    = we;
    req_addr  = addr;
    req_wdata = wdata;
    req_be    = be;
    @(negedge clk);
    req_valid = 1'b0;
    req_we    = 1'b0;
    while (!resp_valid && cycles < ApbTimeoutCycles + 8) begin
      @(negedge clk);
      cycles++;
    end
    if (!resp_valid) begin
      missing++;
      $display("no response from the DUT for address %h", addr);
    end
    @(negedge clk);
  endtask

  initial begin
    logic [31:0] r;
    logic [63:0] a;
    logic [63:0] last_a;
    logic [63:0] alias_a;
    clk       = 1'b0;
    reset     = 1'b1;
    req_valid = 1'b0;
    req_we    = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_be    = '0;
    prdata    = '0;
    pready    = 1'b0;
    pslverr   = 1'b0;
    stall     = 1'b0;
    test_id   = 0;
    seed      = 13;
    waits     = 0;
    missing   = 0;
    for (int i = 0; i < 1024; i++) begin
      slave_regs[i] = '0;
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;

    // L2 with aliased addresses above the word count
    test_id = 1;
    last_a  = soc_map_pkg::DramBase;
    for (int i = 0; i < 16; i++) begin
      r       = $random(seed);
      a       = soc_map_pkg::DramBase + {51'b0, r[9:0], 3'b0};
      alias_a = a + 64'(L2NumWords) * 64'd8 * {62'b0, r[11:10]};
      access(1'b1, a, {$random(seed), $random(seed)}, 8'hff);
      access(1'b1, alias_a, {$random(seed), $random(seed)}, r[23:16]);
      access(1'b0, a, '0, 8'hff);
      last_a = a;
    end

    test_id = 2;
    access(1'b1, soc_map_pkg::CtrlBase, {$random(seed), $random(seed)}, 8'h00);
    access(1'b0, soc_map_pkg::CtrlBase, '0, 8'hff);
    access(1'b0, soc_map_pkg::CtrlBase + 64'h8, '0, 8'hff);
    access(1'b0, soc_map_pkg::CtrlBase + 64'h10, '0, 8'hff);
    access(1'b0, soc_map_pkg::CtrlBase + 64'h18, '0, 8'hff);

    test_id = 3;
    for (int i = 0; i < 10; i++) begin
      r = $random(seed);
      a = soc_map_pkg::UartBase + {53'b0, r[10:2], 2'b0};
      access(1'b1, a, {$random(seed), $random(seed)}, 8'hff);
      access(1'b0, a, '0, 8'hff);
    end

    test_id = 4;
    access(1'b1, soc_map_pkg::UartBase + 64'h804, 64'h1234_5678, 8'hff);
    access(1'b0, soc_map_pkg::UartBase + 64'hffc, '0, 8'hff);

    // Slave never answers
    test_id = 5;
    stall   = 1'b1;
    access(1'b0, soc_map_pkg::UartBase + 64'h10, '0, 8'hff);
    stall   = 1'b0;
    access(1'b0, last_a, '0, 8'hff);

    test_id = 6;
    access(1'b0, 64'h0, '0, 8'hff);
    access(1'b1, 64'h1_0000_0000, 64'hdead_beef, 8'hff);
    access(1'b0, 64'hC000_1000, '0, 8'hff);

    repeat (2) @(negedge clk);
    $display("errors: %0d mismatches, %0d missing responses", check_errors, missing);
    if (check_errors == 0 && missing == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule : soc_tb

`default_nettype wire

// File: verification/soc_checker.sv
// Response checker with reference model
`timescale 1ns/1ps
`default_nettype none

module soc_checker #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        req_valid_i,
  input  logic        req_we_i,
  input  logic [63:0] req_addr_i,
  input  logic [63:0] req_wdata_i,
  input  logic [7:0]  req_be_i,
  input  logic        resp_valid_i,
  input  logic [63:0] resp_rdata_i,
  input  logic        resp_err_i,
  input  logic [63:0] exit_i,
  input  logic        psel_i,
  input  logic        stall_i,
  input  int          test_id_i,
  output int          err_count_o
);

  logic [63:0] l2_shadow [L2NumWords];
  logic [31:0] uart_shadow [1024];
  logic [63:0] exit_shadow;
  logic [64:0] exp_q;
  int          test_q;
  int          errors;
  logic        pending_q;
  logic        fixed_q;

  assign err_count_o = errors;

  initial begin
    errors      = 0;
    exit_shadow = '0;
    for (int i = 0; i < 1024; i++) begin
      uart_shadow[i] = '0;
    end
  end

  function automatic string test_name(input int id);
    case (id)
      1:       return "l2_rw";
      2:       return "ctrl_regs";
      3:       return "uart_rw";
      4:       return "uart_slverr";
      5:       return "uart_timeout";
      default: return "unmapped";
    endcase
  endfunction

  // UART has variable latency, every other target answers the next cycle
  function automatic logic in_uart(input logic [63:0] addr);
    return (addr >= soc_map_pkg::UartBase) &&
           (addr < soc_map_pkg::UartBase + soc_map_pkg::UartLength);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model returning {err, rdata}
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [64:0] predict(input logic we, input logic [63:0] addr,
                                          input logic [63:0] wdata, input logic [7:0] be,
                                          input logic stall);
    logic [63:0] off;
    int unsigned idx;
    logic        err;
    if (addr >= soc_map_pkg::DramBase &&
        addr < soc_map_pkg::DramBase + soc_map_pkg::DramLength) begin
      idx = int'((addr >> 3) % 64'(L2NumWords));
      if (!we) begin
        return {1'b0, l2_shadow[idx]};
      end
      for (int b = 0; b < 8; b++) begin
        if (be[b]) begin
          l2_shadow[idx][8*b +: 8] = wdata[8*b +: 8];
        end
      end
      return '0;
    end
    if (addr >= soc_map_pkg::UartBase &&
        addr < soc_map_pkg::UartBase + soc_map_pkg::UartLength) begin
      off = addr - soc_map_pkg::UartBase;
      err = stall || (off >= 64'h800);
      if (we && !err) begin
        uart_shadow[off[11:2]] = wdata[31:0];
      end
      if (we || err) begin
        return {err, 64'h0};
      end
      return {1'b0, 32'h0, uart_shadow[off[11:2]]};
    end
    if (addr >= soc_map_pkg::CtrlBase &&
        addr < soc_map_pkg::CtrlBase + soc_map_pkg::CtrlLength) begin
      if (we) begin
        if (addr[11:0] == 12'h000) begin
          exit_shadow = wdata;
        end
        return '0;
      end
      case (addr[11:0])
        12'h000: return {1'b0, exit_shadow};
        12'h008: return {1'b0, 64'h8000_0000};
        12'h010: return {1'b0, 64'hC000_0000};
        default: return '0;
      endcase
    end
    return {1'b1, 64'h0};
  endfunction

  always @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
      fixed_q   <= 1'b0;
    end else begin
      if (resp_valid_i) begin
        if (!pending_q) begin
          errors++;
          $display("response from the DUT without a pending request");
        end else begin
          if ({resp_err_i, resp_rdata_i} !== exp_q) begin
            errors++;
            $display("error %s expected %h actual %h", test_name(test_q), exp_q,
                     {resp_err_i, resp_rdata_i});
          end
          if (exit_i !== exit_shadow) begin
            errors++;
            $display("error %s_exit expected %h actual %h", test_name(test_q), exit_shadow,
                     exit_i);
          end
          if (psel_i !== 1'b0) begin
            errors++;
            $display("error %s_psel expected 0 actual %b", test_name(test_q), psel_i);
          end
        end
        pending_q <= 1'b0;
      end else if (pending_q && fixed_q) begin
        errors++;
        $display("%s response did not arrive one cycle after the strobe",
                 test_name(test_q));
        fixed_q <= 1'b0;
      end
      if (req_valid_i) begin
        exp_q     <= predict(req_we_i, req_addr_i, req_wdata_i, req_be_i, stall_i);
        test_q    <= test_id_i;
        pending_q <= 1'b1;
        fixed_q   <= !in_uart(req_addr_i);
      end
    end
  end

endmodule : soc_checker

`default_nettype wire

// File: verification/soc_assert.sv
// Host and APB protocol assertions
`timescale 1ns/1ps
`default_nettype none

module soc_assert (
  input logic clk_i,
  input logic reset_i,
  input logic req_valid_i,
  input logic resp_valid_i,
  input logic psel_i,
  input logic penable_i
);

  logic pending_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
    end else if (req_valid_i) begin
      pending_q <= 1'b1;
    end else if (resp_valid_i) begin
      pending_q <= 1'b0;
    end
  end

  // One request in flight
  no_overlap_a : assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i |-> !pending_q)
    else $error("strobe issued while a request is pending");

  // ACCESS only after SETUP
  penable_after_setup_a : assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(penable_i) |-> $past(psel_i && !penable_i))
    else $error("penable rose without a SETUP cycle");

  psel_until_resp_a : assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(psel_i) |-> resp_valid_i)
    else $error("psel dropped before the response");

endmodule : soc_assert

bind soc_top soc_assert i_soc_assert (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .req_valid_i (req_valid_i),
  .resp_valid_i(resp_valid_o),
  .psel_i      (uart_psel_o),
  .penable_i   (uart_penable_o)
);

`default_nettype wire

// File: hdl/soc_top.sv
// SoC memory fabric top level
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
  parameter int unsigned L2NumWords       = 1024,
  parameter int unsigned ApbTimeoutCycles = 16
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  // Host port
  input  logic                                 req_valid_i,
  input  logic                                 req_we_i,
  input  logic [soc_bus_pkg::AddrWidth-1:0]    req_addr_i,
  input  logic [soc_bus_pkg::DataWidth-1:0]    req_wdata_i,
  input  logic [soc_bus_pkg::StrbWidth-1:0]    req_be_i,
  output logic                                 resp_valid_o,
  output logic [soc_bus_pkg::DataWidth-1:0]    resp_rdata_o,
  output logic                                 resp_err_o,
  // UART APB port
  output logic                                 uart_psel_o,
  output logic                                 uart_penable_o,
  output logic                                 uart_pwrite_o,
  output logic [soc_bus_pkg::ApbAddrWidth-1:0] uart_paddr_o,
  output logic [soc_bus_pkg::ApbDataWidth-1:0] uart_pwdata_o,
  input  logic [soc_bus_pkg::ApbDataWidth-1:0] uart_prdata_i,
  input  logic                                 uart_pready_i,
  input  logic                                 uart_pslverr_i,
  output logic [soc_bus_pkg::DataWidth-1:0]    exit_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Fabric wires
  ////////////////////////////////////////////////////////////////////////////

  logic                              l2_req;
  logic                              uart_req;
  logic                              ctrl_req;
  logic                              we;
  logic [soc_bus_pkg::AddrWidth-1:0] addr;
  logic [soc_bus_pkg::DataWidth-1:0] wdata;
  logic [soc_bus_pkg::StrbWidth-1:0] be;

  logic                              l2_valid;
  logic [soc_bus_pkg::DataWidth-1:0] l2_rdata;
  logic                              uart_valid;
  logic [soc_bus_pkg::DataWidth-1:0] uart_rdata;
  logic                              uart_err;
  logic                              ctrl_valid;
  logic [soc_bus_pkg::DataWidth-1:0] ctrl_rdata;

  addr_decoder i_addr_decoder (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_be_i    (req_be_i),
    .l2_valid_i  (l2_valid),
    .l2_rdata_i  (l2_rdata),
    .uart_valid_i(uart_valid),
    .uart_rdata_i(uart_rdata),
    .uart_err_i  (uart_err),
    .ctrl_valid_i(ctrl_valid),
    .ctrl_rdata_i(ctrl_rdata),
    .l2_req_o    (l2_req),
    .uart_req_o  (uart_req),
    .ctrl_req_o  (ctrl_req),
    .we_o        (we),
    .addr_o      (addr),
    .wdata_o     (wdata),
    .be_o        (be),
    .resp_valid_o(resp_valid_o),
    .resp_rdata_o(resp_rdata_o),
    .resp_err_o  (resp_err_o)
  );

  l2_mem #(
    .L2NumWords(L2NumWords)
  ) i_l2_mem (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (l2_req),
    .we_i   (we),
    .addr_i (addr),
    .wdata_i(wdata),
    .be_i   (be),
    .valid_o(l2_valid),
    .rdata_o(l2_rdata)
  );

  apb_bridge_fsm #(
    .ApbTimeoutCycles(ApbTimeoutCycles)
  ) i_apb_bridge (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (uart_req),
    .we_i     (we),
    .addr_i   (addr),
    .wdata_i  (wdata),
    .psel_o   (uart_psel_o),
    .penable_o(uart_penable_o),
    .pwrite_o (uart_pwrite_o),
    .paddr_o  (uart_paddr_o),
    .pwdata_o (uart_pwdata_o),
    .prdata_i (uart_prdata_i),
    .pready_i (uart_pready_i),
    .pslverr_i(uart_pslverr_i),
    .valid_o  (uart_valid),
    .rdata_o  (uart_rdata),
    .err_o    (uart_err)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (ctrl_req),
    .we_i   (we),
    .addr_i (addr),
    .wdata_i(wdata),
    .valid_o(ctrl_valid),
    .rdata_o(ctrl_rdata),
    .exit_o (exit_o)
  );

endmodule : soc_top

`default_nettype wire

// File: hdl/addr_decoder.sv
// Host request decoder and response mux
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
  input  logic                              clk_i,
  input  logic                              reset_i,
  // Host request
  input  logic                              req_valid_i,
  input  logic                              req_we_i,
  input  logic [soc_bus_pkg::AddrWidth-1:0] req_addr_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] req_wdata_i,
  input  logic [soc_bus_pkg::StrbWidth-1:0] req_be_i,
  // Target responses
  input  logic                              l2_valid_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] l2_rdata_i,
  input  logic                              uart_valid_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] uart_rdata_i,
  input  logic                              uart_err_i,
  input  logic                              ctrl_valid_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] ctrl_rdata_i,
  // Target requests
  output logic                              l2_req_o,
  output logic                              uart_req_o,
  output logic                              ctrl_req_o,
  output logic                              we_o,
  output logic [soc_bus_pkg::AddrWidth-1:0] addr_o,
  output logic [soc_bus_pkg::DataWidth-1:0] wdata_o,
  output logic [soc_bus_pkg::StrbWidth-1:0] be_o,
  // Host response
  output logic                              resp_valid_o,
  output logic [soc_bus_pkg::DataWidth-1:0] resp_rdata_o,
  output logic                              resp_err_o
);

  soc_map_pkg::target_e              tgt_d;
  soc_map_pkg::target_e              tgt_q;
  logic                              pending_q;
  logic                              we_q;
  logic                              sel_valid;
  logic [soc_bus_pkg::DataWidth-1:0] sel_rdata;
  logic                              sel_err;

  function automatic logic in_region(
    input logic [soc_bus_pkg::AddrWidth-1:0] addr,
    input logic [soc_bus_pkg::AddrWidth-1:0] base,
    input logic [soc_bus_pkg::AddrWidth-1:0] len
  );
    return (addr >= base) && (addr < base + len);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Request routing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (in_region(req_addr_i, soc_map_pkg::DramBase, soc_map_pkg::DramLength)) begin
      tgt_d = soc_map_pkg::TGT_L2;
    end else if (in_region(req_addr_i, soc_map_pkg::UartBase, soc_map_pkg::UartLength)) begin
      tgt_d = soc_map_pkg::TGT_UART;
    end else if (in_region(req_addr_i, soc_map_pkg::CtrlBase, soc_map_pkg::CtrlLength)) begin
      tgt_d = soc_map_pkg::TGT_CTRL;
    end else begin
      tgt_d = soc_map_pkg::TGT_NONE;
    end
  end

  assign l2_req_o   = req_valid_i && (tgt_d == soc_map_pkg::TGT_L2);
  assign uart_req_o = req_valid_i && (tgt_d == soc_map_pkg::TGT_UART);
  assign ctrl_req_o = req_valid_i && (tgt_d == soc_map_pkg::TGT_CTRL);
  assign we_o       = req_we_i;
  assign addr_o     = req_addr_i;
  assign wdata_o    = req_wdata_i;
  assign be_o       = req_be_i;

  // Remember who owes the response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
      tgt_q     <= soc_map_pkg::TGT_NONE;
    end else if (req_valid_i) begin
      pending_q <= 1'b1;
      tgt_q     <= tgt_d;
    end else if (resp_valid_o) begin
      pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      we_q <= req_we_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response merge
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sel_valid = 1'b0;
    sel_rdata = '0;
    sel_err   = 1'b0;
    case (tgt_q)
      soc_map_pkg::TGT_L2: begin
        sel_valid = l2_valid_i;
        sel_rdata = l2_rdata_i;
      end
      soc_map_pkg::TGT_UART: begin
        sel_valid = uart_valid_i;
        sel_rdata = uart_rdata_i;
        sel_err   = uart_err_i;
      end
      soc_map_pkg::TGT_CTRL: begin
        sel_valid = ctrl_valid_i;
        sel_rdata = ctrl_rdata_i;
      end
      // Decoder answers unmapped addresses one cycle after the strobe
      default: begin
        sel_valid = 1'b1;
        sel_err   = 1'b1;
      end
    endcase
  end

  assign resp_valid_o = pending_q && sel_valid;
  assign resp_rdata_o = we_q ? '0 : sel_rdata;
  assign resp_err_o   = sel_err;

endmodule : addr_decoder

`default_nettype wire

// File: hdl/ctrl_regs.sv
// SoC control registers
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [soc_bus_pkg::AddrWidth-1:0] addr_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] wdata_i,
  output logic                              valid_o,
  output logic [soc_bus_pkg::DataWidth-1:0] rdata_o,
  output logic [soc_bus_pkg::DataWidth-1:0] exit_o
);

  localparam logic [63:0] DramEnd = soc_map_pkg::DramBase + soc_map_pkg::DramLength;

  logic [11:0] reg_off;

  // Region is 4 KiB aligned
  assign reg_off = addr_i[11:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
      exit_o  <= '0;
    end else begin
      valid_o <= req_i;
      if (req_i && we_i && (reg_off == soc_map_pkg::CtrlExitOffset)) begin
        exit_o <= wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      case (reg_off)
        soc_map_pkg::CtrlExitOffset:     rdata_o <= exit_o;
        soc_map_pkg::CtrlDramBaseOffset: rdata_o <= soc_map_pkg::DramBase;
        soc_map_pkg::CtrlDramEndOffset:  rdata_o <= DramEnd;
        default:                         rdata_o <= '0;
      endcase
    end
  end

endmodule : ctrl_regs

`default_nettype wire

// File: hdl/apb_bridge_fsm.sv
// APB master for the UART region
`timescale 1ns/1ps
`default_nettype none

module apb_bridge_fsm #(
  parameter int unsigned ApbTimeoutCycles = 16
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [soc_bus_pkg::AddrWidth-1:0]    addr_i,
  input  logic [soc_bus_pkg::DataWidth-1:0]    wdata_i,
  // APB
  output logic                                 psel_o,
  output logic                                 penable_o,
  output logic                                 pwrite_o,
  output logic [soc_bus_pkg::ApbAddrWidth-1:0] paddr_o,
  output logic [soc_bus_pkg::ApbDataWidth-1:0] pwdata_o,
  input  logic [soc_bus_pkg::ApbDataWidth-1:0] prdata_i,
  input  logic                                 pready_i,
  input  logic                                 pslverr_i,
  // Response
  output logic                                 valid_o,
  output logic [soc_bus_pkg::DataWidth-1:0]    rdata_o,
  output logic                                 err_o
);

  localparam int unsigned PadWidth = soc_bus_pkg::DataWidth - soc_bus_pkg::ApbDataWidth;

  soc_bus_pkg::apb_state_e           state_q;
  soc_bus_pkg::apb_state_e           state_d;
  logic                              in_access;
  logic                              expired;
  logic                              done;
  logic [soc_bus_pkg::AddrWidth-1:0] offset;

  assign in_access = (state_q == soc_bus_pkg::APB_ACCESS);
  assign done      = in_access && (pready_i || expired);
  assign offset    = addr_i - soc_map_pkg::UartBase;

  apb_timeout_timer #(
    .ApbTimeoutCycles(ApbTimeoutCycles)
  ) i_timeout_timer (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .run_i    (in_access),
    .expired_o(expired)
  );

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      soc_bus_pkg::APB_IDLE: begin
        if (req_i) begin
          state_d = soc_bus_pkg::APB_SETUP;
        end
      end
      soc_bus_pkg::APB_SETUP: begin
        state_d = soc_bus_pkg::APB_ACCESS;
      end
      soc_bus_pkg::APB_ACCESS: begin
        if (done) begin
          state_d = soc_bus_pkg::APB_IDLE;
        end
      end
      default: begin
        state_d = soc_bus_pkg::APB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= soc_bus_pkg::APB_IDLE;
      valid_o <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_o <= done;
    end
  end

  // Request latch and response capture
  always_ff @(posedge clk_i) begin
    if (req_i && (state_q == soc_bus_pkg::APB_IDLE)) begin
      pwrite_o <= we_i;
      paddr_o  <= offset[soc_bus_pkg::ApbAddrWidth-1:0];
      pwdata_o <= wdata_i[soc_bus_pkg::ApbDataWidth-1:0];
    end
    if (in_access) begin
      // a timeout reports an error with zero data
      rdata_o <= pready_i ? {{PadWidth{1'b0}}, prdata_i} : '0;
      err_o   <= pready_i ? pslverr_i : 1'b1;
    end
  end

  assign psel_o    = (state_q == soc_bus_pkg::APB_SETUP) || in_access;
  assign penable_o = in_access;

endmodule : apb_bridge_fsm

`default_nettype wire

// File: hdl/apb_timeout_timer.sv
// APB access timeout counter
`timescale 1ns/1ps
`default_nettype none

module apb_timeout_timer #(
  parameter int unsigned ApbTimeoutCycles = 16
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic run_i,
  output logic expired_o
);

  localparam int unsigned CntWidth = $clog2(ApbTimeoutCycles + 1);

  logic [CntWidth-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (reset_i || !run_i) begin
      cnt_q <= '0;
    end else if (!expired_o) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Fires in the last allowed ACCESS cycle
  assign expired_o = run_i && (cnt_q == CntWidth'(ApbTimeoutCycles - 1));

endmodule : apb_timeout_timer

`default_nettype wire

// File: hdl/l2_mem.sv
// Byte-enabled L2 word memory
`timescale 1ns/1ps
`default_nettype none

module l2_mem #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [soc_bus_pkg::AddrWidth-1:0] addr_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] wdata_i,
  input  logic [soc_bus_pkg::StrbWidth-1:0] be_i,
  output logic                              valid_o,
  output logic [soc_bus_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned IdxWidth = $clog2(L2NumWords);
  localparam int unsigned OffWidth = $clog2(soc_bus_pkg::StrbWidth);

  logic [soc_bus_pkg::DataWidth-1:0] mem_q [L2NumWords];
  logic [IdxWidth-1:0]               idx;

  // Index wraps as upper address bits are dropped
  assign idx = addr_i[OffWidth +: IdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < soc_bus_pkg::StrbWidth; b++) begin
          if (be_i[b]) begin
            mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

  // One-cycle latency
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= req_i;
    end
  end

endmodule : l2_mem

`default_nettype wire

// File: hdl/soc_bus_pkg.sv
// Host and APB bus definitions
`default_nettype none

package soc_bus_pkg;

  // Host side
  localparam int unsigned AddrWidth = 64;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // UART side
  localparam int unsigned ApbAddrWidth = 32;
  localparam int unsigned ApbDataWidth = 32;

  typedef enum logic [1:0] {
    APB_IDLE   = 2'd0,
    APB_SETUP  = 2'd1,
    APB_ACCESS = 2'd2
  } apb_state_e;

endpackage : soc_bus_pkg

`default_nettype wire

// File: hdl/soc_map_pkg.sv
// SoC memory map
`default_nettype none

package soc_map_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Regions
  ////////////////////////////////////////////////////////////////////////////

  // 1 GiB of DRAM backed by L2
  localparam logic [63:0] DramBase   = 64'h0000_0000_8000_0000;
  localparam logic [63:0] DramLength = 64'h0000_0000_4000_0000;

  localparam logic [63:0] UartBase   = 64'h0000_0000_C000_0000;
  localparam logic [63:0] UartLength = 64'h0000_0000_0000_1000;

  localparam logic [63:0] CtrlBase   = 64'h0000_0000_D000_0000;
  localparam logic [63:0] CtrlLength = 64'h0000_0000_0000_1000;

  // Control register offsets
  localparam logic [11:0] CtrlExitOffset     = 12'h000;
  localparam logic [11:0] CtrlDramBaseOffset = 12'h008;
  localparam logic [11:0] CtrlDramEndOffset  = 12'h010;

  typedef enum logic [1:0] {
    TGT_L2   = 2'd0,
    TGT_UART = 2'd1,
    TGT_CTRL = 2'd2,
    TGT_NONE = 2'd3
  } target_e;

endpackage : soc_map_pkg

`default_nettype wire
